//--- Bender.yml
package:
  name: rv64Core

sources:
  - include_dirs:
      - source
    files:
      - source/rv64Pkg.sv
      - source/instructionRom.sv
      - source/instructionDecoder.sv
      - source/registerFile.sv
      - source/fetchSequencer.sv
      - source/rv64Core.sv

  - target: simulation
    include_dirs:
      - source
    files:
      - sim/rv64CoreTb.sv

//--- rv64Core.f
+incdir+source
source/rv64Pkg.sv
source/instructionRom.sv
source/instructionDecoder.sv
source/registerFile.sv
source/fetchSequencer.sv
source/rv64Core.sv
sim/rv64CoreTb.sv

//--- sim/rv64CoreTb.sv
// rv64 front end testbench
`timescale 1ns/1ps
`default_nettype none

module rv64CoreTb import rv64Pkg::*; ();

	localparam int MAX_ROWS = 24;
	localparam int FETCH_TIMEOUT = 8; // cycles allowed to get back to fetch

	logic clock;
	logic reset_n;
	logic loadEnable;
	romIndex loadAddress;
	instrWord loadData;
	pcValue pc;
	beatState beat;
	instrWord instruction;
	rv64Pkg::instrKind kindOut;
	xValue immOut;
	xValue linkValue; // x1

	// program table, rows in execution order
	romIndex rowAddr [MAX_ROWS]; // rom word index
	instrWord rowWord [MAX_ROWS];
	rv64Pkg::instrKind rowKind [MAX_ROWS];
	xValue rowImm [MAX_ROWS];
	pcValue rowNextPc [MAX_ROWS]; // pc once the instruction is done
	logic rowLinkWrite [MAX_ROWS]; // 0 means x1 unchanged
	xValue rowLink [MAX_ROWS];
	int rowCount = 0;

	int errorCount = 0;
	int timeoutCount = 0;

	rv64Core uut (
		.clock(clock),
		.reset_n(reset_n),
		.loadEnable(loadEnable),
		.loadAddress(loadAddress),
		.loadData(loadData),
		.pc(pc),
		.beat(beat),
		.instruction(instruction),
		.instrKind(kindOut),
		.imm(immOut),
		.linkValue(linkValue)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	task automatic addRow(input romIndex addr, input instrWord word,
		input rv64Pkg::instrKind kind, input xValue imm, input pcValue nextPc,
		input logic linkWrite, input xValue link);
		rowAddr[rowCount] = addr;
		rowWord[rowCount] = word;
		rowKind[rowCount] = kind;
		rowImm[rowCount] = imm;
		rowNextPc[rowCount] = nextPc;
		rowLinkWrite[rowCount] = linkWrite;
		rowLink[rowCount] = link;
		rowCount++;
	endtask

	// one instruction per class, jal forward and jalr back through x1
	task automatic buildProgram();
		addRow(7'd0, 32'h123452B7, kindLui, 64'h12345000, 64'd1, 1'b0, 64'd0); // lui x5
		// jal x1, +16 bytes lands on word 5
		addRow(7'd1, 32'h010000EF, kindJal, 64'd16, 64'd5, 1'b1, 64'd2);
		addRow(7'd5, 32'hFFFFF317, kindAuipc, 64'hFFFFFFFFFFFFF000, 64'd6, 1'b0, 64'd0);
		addRow(7'd6, 32'hFF813383, kindLd, 64'hFFFFFFFFFFFFFFF8, 64'd7, 1'b0, 64'd0); // ld -8
		addRow(7'd7, 32'h00713C23, kindSd, 64'd24, 64'd8, 1'b0, 64'd0); // sd x7, 24(x2)
		// ret, back to word 2
		addRow(7'd8, 32'h00008067, kindJalr, 64'd0, 64'd2, 1'b0, 64'd0);
		addRow(7'd2, 32'h00628433, kindAdd, 64'd0, 64'd3, 1'b0, 64'd0); // r-type, no imm
		addRow(7'd3, 32'hFFF00493, kindAddi, 64'hFFFFFFFFFFFFFFFF, 64'd4, 1'b0, 64'd0);
		// jal x0 forward 52 bytes to word 17
		addRow(7'd4, 32'h0340006F, kindJal, 64'd52, 64'd17, 1'b0, 64'd0);
		// jal x0 back 28 bytes to word 10
		addRow(7'd17, 32'hFE5FF06F, kindJal, 64'hFFFFFFFFFFFFFFE4, 64'd10, 1'b0, 64'd0);
		addRow(7'd10, 32'h0054851B, kindAddiw, 64'd5, 64'd11, 1'b0, 64'd0);
		addRow(7'd11, 32'h406285BB, kindSubw, 64'd0, 64'd12, 1'b0, 64'd0);
		// beq -4 is decoded only, pc still steps
		addRow(7'd12, 32'hFE628EE3, kindBeq, 64'hFFFFFFFFFFFFFFFC, 64'd13, 1'b0, 64'd0);
		addRow(7'd13, 32'h0FF0000F, kindFence, 64'd255, 64'd14, 1'b0, 64'd0); // fence
		addRow(7'd14, 32'h00000073, kindEcall, 64'd0, 64'd15, 1'b0, 64'd0);
		addRow(7'd15, 32'hC0002673, kindCsrrs, 64'hFFFFFFFFFFFFFC00, 64'd16, 1'b0, 64'd0);
		addRow(7'd16, 32'hFFFFFFFF, kindIllegal, 64'd0, 64'd17, 1'b0, 64'd0); // opcode 7f
	endtask

	task automatic checkWord(input instrWord got, input instrWord exp, input string what);
		if (got !== exp) begin
			errorCount++;
			$display("error at %0t: %s expected %h, got %h", $time, what, exp, got);
		end
	endtask

	task automatic checkKind(input rv64Pkg::instrKind got, input rv64Pkg::instrKind exp,
		input string what);
		if (got !== exp) begin
			errorCount++;
			$display("error at %0t: %s expected %s, got %s", $time, what, exp.name(), got.name());
		end
	endtask

	task automatic checkValue(input xValue got, input xValue exp, input string what);
		if (got !== exp) begin
			errorCount++;
			$display("error at %0t: %s expected %h, got %h", $time, what, exp, got);
		end
	endtask

	task automatic checkPc(input pcValue got, input pcValue exp, input string what);
		if (got !== exp) begin
			errorCount++;
			$display("error at %0t: %s expected %0d, got %0d", $time, what, exp, got);
		end
	endtask

	task automatic checkBeat(input beatState got, input beatState exp, input string what);
		if (got !== exp) begin
			errorCount++;
			$display("error at %0t: %s expected %s, got %s", $time, what, exp.name(), got.name());
		end
	endtask

	task automatic checkCycles(input int got, input int exp, input string what);
		if (got != exp) begin
			errorCount++;
			$display("error at %0t: %s expected %0d cycles, got %0d", $time, what, exp, got);
		end
	endtask

	// step falling edges until beat is back at fetch
	task automatic waitForFetch(output int cycles);
		cycles = 0;
		while ((beat !== beatFetch) && (cycles < FETCH_TIMEOUT)) begin
			@(negedge clock);
			cycles++;
		end
		if (beat !== beatFetch) begin
			timeoutCount++;
			$display("timeout at %0t: the sequencer never came back to the fetch beat", $time);
		end
	endtask

	initial begin
		int retireCycles;
		int expRetire;
		xValue linkExp;

		reset_n = 1'b0;
		loadEnable = 1'b1; // keep fetch held until the program is in
		loadAddress = '0;
		loadData = '0;
		linkExp = '0;
		buildProgram();

		repeat (3) @(posedge clock);
		reset_n <= 1'b1;
		@(negedge clock);
		checkPc(pc, 64'd0, "pc after reset");
		checkBeat(beat, beatFetch, "beat after reset");
		checkWord(instruction, 32'd0, "instruction after reset");
		checkKind(kindOut, kindNone, "instrKind after reset");
		checkValue(immOut, 64'd0, "imm after reset");
		checkValue(linkValue, 64'd0, "x1 after reset");

		// program load, one word per edge
		for (int i = 0; i < rowCount; i++) begin
			@(posedge clock);
			loadAddress <= rowAddr[i];
			loadData <= rowWord[i];
		end
		@(posedge clock);
		loadEnable <= 1'b0;
		@(negedge clock);
		checkPc(pc, 64'd0, "pc held during load");
		checkBeat(beat, beatFetch, "beat held during load");

		for (int i = 0; (i < rowCount) && (timeoutCount == 0); i++) begin
			@(negedge clock); // fetch edge has passed
			checkWord(instruction, rowWord[i], "instruction");
			checkKind(kindOut, rowKind[i], "instrKind");
			checkValue(immOut, rowImm[i], "imm");
			// jumps stay in fetch, everything else retires for one cycle
			expRetire = ((rowKind[i] == kindJal) || (rowKind[i] == kindJalr)) ? 0 : 1;
			checkBeat(beat, (expRetire == 0) ? beatFetch : beatRetire, "beat after fetch");
			waitForFetch(retireCycles);
			if (timeoutCount == 0) begin
				checkCycles(retireCycles, expRetire, "retire beat");
				checkPc(pc, rowNextPc[i], "pc after instruction");
				if (rowLinkWrite[i]) begin
					linkExp = rowLink[i];
				end
				checkValue(linkValue, linkExp, "x1 after instruction");
			end
		end

		$display("errors %0d, timeouts %0d", errorCount, timeoutCount);
		if ((errorCount == 0) && (timeoutCount == 0)) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/fetchSequencer.sv
// two-beat fetch sequencer
`timescale 1ns/1ps
`default_nettype none

`include "rv64Core_defs.svh"

module fetchSequencer import rv64Pkg::*; (
	input logic clock,
	input logic reset_n,
	input logic loadEnable, // holds everything while the rom loads
	input instrWord fetchWord,
	input rv64Pkg::instrKind kind, // decoded from fetchWord
	input xValue imm,
	input regIndex rd,
	input xValue rs1Value,
	output romIndex fetchIndex,
	output logic writeEnable, // link write for jumps
	output regIndex writeIndex,
	output xValue writeValue,
	output pcValue pc,
	output beatState beat,
	output instrWord instruction, // last fetched word
	output rv64Pkg::instrKind instrKind,
	output xValue immView
);

	logic isJump;
	pcValue nextPc;
	pcValue jumpTarget;
	xValue jumpOffset;

	assign fetchIndex = pc[`ROM_ADDR_WIDTH-1:0]; // low bits address the rom
	assign nextPc = pc + 1'b1;
	assign isJump = (kind == kindJal) || (kind == kindJalr);
	assign jumpOffset = $signed(imm) >>> 2; // byte offset to words, sign kept

	// link write happens on the fetch edge itself
	assign writeEnable = !loadEnable && (beat == beatFetch) && isJump;
	assign writeIndex = rd;
	assign writeValue = nextPc; // return to the following word

	// targets are word indices
	always_comb begin
		if (kind == kindJalr) begin
			jumpTarget = rs1Value + imm;
		end else begin
			jumpTarget = pc + jumpOffset;
		end
	end

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			pc <= '0;
			beat <= beatFetch;
			instruction <= '0;
			instrKind <= kindNone;
			immView <= '0;
		end else if (!loadEnable) begin
			case (beat)
				beatFetch: begin
					instruction <= fetchWord;
					instrKind <= kind;
					immView <= imm;
					if (isJump) begin
						pc <= jumpTarget; // one-cycle jump, stay in fetch
					end else begin
						beat <= beatRetire;
					end
				end
				beatRetire: begin
					pc <= nextPc;
					beat <= beatFetch;
				end
				default: beat <= beatFetch;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/instructionDecoder.sv
// rv64i instruction decoder
`timescale 1ns/1ps
`default_nettype none

`include "rv64Core_defs.svh"

module instructionDecoder import rv64Pkg::*; (
	input instrWord word,
	output instrKind kind,
	output xValue imm, // sign-extended, format from opcode
	output regIndex rd,
	output regIndex rs1
);

	logic [6:0] opcode;
	logic [2:0] func3;
	logic [6:0] func7;
	logic [11:0] func12;

	assign opcode = word[6:0];
	assign func3 = word[14:12];
	assign func7 = word[31:25];
	assign func12 = word[31:20]; // system ops only
	assign rd = word[11:7];
	assign rs1 = word[19:15];

	// kind lookup, opcode then func fields
	always_comb begin
		kind = kindIllegal; // anything unmatched
		case (opcode)
			`OPCODE_LUI: kind = kindLui;
			`OPCODE_AUIPC: kind = kindAuipc;
			`OPCODE_LOAD: begin
				case (func3)
					3'b000: kind = kindLb;
					3'b100: kind = kindLbu;
					3'b001: kind = kindLh;
					3'b101: kind = kindLhu;
					3'b010: kind = kindLw;
					3'b110: kind = kindLwu;
					3'b011: kind = kindLd;
					default: kind = kindIllegal;
				endcase
			end
			`OPCODE_STORE: begin
				case (func3)
					3'b000: kind = kindSb;
					3'b001: kind = kindSh;
					3'b010: kind = kindSw;
					3'b011: kind = kindSd;
					default: kind = kindIllegal;
				endcase
			end
			`OPCODE_OP: begin
				case (func3)
					3'b000: begin
						if (func7 == 7'b0000000) kind = kindAdd;
						else if (func7 == 7'b0100000) kind = kindSub;
					end
					3'b001: kind = kindSll;
					3'b010: kind = kindSlt;
					3'b011: kind = kindSltu;
					3'b100: kind = kindXor;
					3'b101: begin
						if (func7 == 7'b0000000) kind = kindSrl;
						else if (func7 == 7'b0100000) kind = kindSra;
					end
					3'b110: kind = kindOr;
					3'b111: kind = kindAnd;
				endcase
			end
			`OPCODE_OP_IMM: begin
				case (func3)
					3'b000: kind = kindAddi;
					3'b010: kind = kindSlti;
					3'b011: kind = kindSltiu;
					3'b100: kind = kindXori;
					3'b110: kind = kindOri;
					3'b111: kind = kindAndi;
					3'b001: kind = kindSlli;
					3'b101: begin // shamt is 6 bits here, so only [31:26] selects
						if (func7[6:1] == 6'b000000) kind = kindSrli;
						else if (func7[6:1] == 6'b010000) kind = kindSrai;
					end
				endcase
			end
			`OPCODE_OP_IMM_32: begin
				case (func3)
					3'b000: kind = kindAddiw;
					3'b001: kind = kindSlliw;
					3'b101: begin
						if (func7 == 7'b0000000) kind = kindSrliw;
						else if (func7 == 7'b0100000) kind = kindSraiw;
					end
					default: kind = kindIllegal;
				endcase
			end
			`OPCODE_OP_32: begin
				case (func3)
					3'b000: begin
						if (func7 == 7'b0000000) kind = kindAddw;
						else if (func7 == 7'b0100000) kind = kindSubw;
					end
					3'b001: kind = kindSllw;
					3'b101: begin
						if (func7 == 7'b0000000) kind = kindSrlw;
						else if (func7 == 7'b0100000) kind = kindSraw;
					end
					default: kind = kindIllegal;
				endcase
			end
			`OPCODE_JAL: kind = kindJal;
			`OPCODE_JALR: kind = kindJalr;
			`OPCODE_BRANCH: begin
				case (func3)
					3'b000: kind = kindBeq;
					3'b001: kind = kindBne;
					3'b100: kind = kindBlt;
					3'b101: kind = kindBge;
					3'b110: kind = kindBltu;
					3'b111: kind = kindBgeu;
					default: kind = kindIllegal;
				endcase
			end
			`OPCODE_MISC_MEM: begin
				if (func3 == 3'b000) kind = kindFence;
				else if (func3 == 3'b001) kind = kindFencei;
			end
			`OPCODE_SYSTEM: begin
				case (func3)
					3'b000: begin // func12 picks the environment call
						if (func12 == 12'h000) kind = kindEcall;
						else if (func12 == 12'h001) kind = kindEbreak;
					end
					3'b001: kind = kindCsrrw;
					3'b010: kind = kindCsrrs;
					3'b011: kind = kindCsrrc;
					3'b101: kind = kindCsrrwi;
					3'b110: kind = kindCsrrsi;
					3'b111: kind = kindCsrrci;
					default: kind = kindIllegal;
				endcase
			end
			default: kind = kindIllegal;
		endcase
	end

	// immediate by format
	always_comb begin
		case (opcode)
			`OPCODE_LOAD, `OPCODE_OP_IMM, `OPCODE_OP_IMM_32, `OPCODE_JALR,
			`OPCODE_MISC_MEM, `OPCODE_SYSTEM: // i-type
				imm = {{(`XLEN-12){word[31]}}, word[31:20]};
			`OPCODE_STORE: // s-type, split field
				imm = {{(`XLEN-12){word[31]}}, word[31:25], word[11:7]};
			`OPCODE_BRANCH: // b-type, bit 0 implied
				imm = {{(`XLEN-13){word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
			`OPCODE_LUI, `OPCODE_AUIPC: // u-type, upper 20 bits
				imm = {{(`XLEN-32){word[31]}}, word[31:12], 12'b0};
			`OPCODE_JAL: // j-type, scrambled order
				imm = {{(`XLEN-21){word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
			default: imm = '0; // r-type and unknown
		endcase
	end

endmodule

`default_nettype wire

//--- source/instructionRom.sv
// instruction program store
`timescale 1ns/1ps
`default_nettype none

`include "rv64Core_defs.svh"

module instructionRom (
	input logic clock,
	input logic loadEnable, // write strobe while loading
	input rv64Pkg::romIndex loadAddress,
	input rv64Pkg::instrWord loadData,
	input rv64Pkg::romIndex fetchIndex,
	output rv64Pkg::instrWord fetchWord
);

	rv64Pkg::instrWord words [`ROM_DEPTH]; // program words

	// load port, one word per edge
	always_ff @(posedge clock) begin
		if (loadEnable && (loadAddress < `ROM_DEPTH)) begin
			words[loadAddress] <= loadData;
		end
	end

	// async fetch so decode sees the word in the same beat
	// past the end reads zero, which decodes as illegal
	assign fetchWord = (fetchIndex < `ROM_DEPTH) ? words[fetchIndex] : '0;

endmodule

`default_nettype wire

//--- source/registerFile.sv
// general register file
`timescale 1ns/1ps
`default_nettype none

`include "rv64Core_defs.svh"

module registerFile import rv64Pkg::*; (
	input logic clock,
	input logic reset_n,
	input logic writeEnable,
	input regIndex writeIndex,
	input xValue writeValue,
	input regIndex readIndex,
	output xValue readValue,
	output xValue linkView // x1, return address
);

	xValue regs [`REG_COUNT];

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && (writeIndex != '0)) begin // x0 never written
			regs[writeIndex] <= writeValue;
		end
	end

	// combinational read, x0 forced to zero
	assign readValue = (readIndex == '0) ? '0 : regs[readIndex];
	assign linkView = regs[1];

endmodule

`default_nettype wire

//--- source/rv64Core.sv
// rv64i front end top
`timescale 1ns/1ps
`default_nettype none

module rv64Core import rv64Pkg::*; (
	input logic clock,
	input logic reset_n,
	input logic loadEnable,
	input romIndex loadAddress,
	input instrWord loadData,
	output pcValue pc,
	output beatState beat,
	output instrWord instruction,
	output rv64Pkg::instrKind instrKind,
	output xValue imm,
	output xValue linkValue // x1
);

	romIndex fetchIndex;
	instrWord fetchWord;
	rv64Pkg::instrKind decKind; // decoder to sequencer
	xValue decImm;
	regIndex decRd;
	regIndex decRs1;
	xValue rs1Value;
	logic writeEnable;
	regIndex writeIndex;
	xValue writeValue;

	instructionRom rom (
		.clock(clock),
		.loadEnable(loadEnable),
		.loadAddress(loadAddress),
		.loadData(loadData),
		.fetchIndex(fetchIndex),
		.fetchWord(fetchWord)
	);

	instructionDecoder decoder (
		.word(fetchWord),
		.kind(decKind),
		.imm(decImm),
		.rd(decRd),
		.rs1(decRs1)
	);

	registerFile regFile (
		.clock(clock),
		.reset_n(reset_n),
		.writeEnable(writeEnable),
		.writeIndex(writeIndex),
		.writeValue(writeValue),
		.readIndex(decRs1), // jalr base
		.readValue(rs1Value),
		.linkView(linkValue)
	);

	fetchSequencer sequencer (
		.clock(clock),
		.reset_n(reset_n),
		.loadEnable(loadEnable),
		.fetchWord(fetchWord),
		.kind(decKind),
		.imm(decImm),
		.rd(decRd),
		.rs1Value(rs1Value),
		.fetchIndex(fetchIndex),
		.writeEnable(writeEnable),
		.writeIndex(writeIndex),
		.writeValue(writeValue),
		.pc(pc),
		.beat(beat),
		.instruction(instruction),
		.instrKind(instrKind),
		.immView(imm)
	);

endmodule

`default_nettype wire

//--- source/rv64Core_defs.svh
// rv64 core constants
`ifndef RV64CORE_DEFS_SVH
`define RV64CORE_DEFS_SVH

// datapath widths
`define XLEN 64 // register and pc width
`define ILEN 32 // one instruction word
`define REG_COUNT 32 // x0 .. x31

// program store
`define ROM_DEPTH 100 // words
`define ROM_ADDR_WIDTH 7 // enough for 100 words

// major opcodes, bits [6:0] of the word
`define OPCODE_LUI 7'b0110111
`define OPCODE_AUIPC 7'b0010111
`define OPCODE_LOAD 7'b0000011
`define OPCODE_STORE 7'b0100011
`define OPCODE_OP 7'b0110011 // register-register
`define OPCODE_OP_IMM 7'b0010011 // register-immediate
`define OPCODE_OP_IMM_32 7'b0011011 // word-sized immediate ops
`define OPCODE_OP_32 7'b0111011 // word-sized register ops
`define OPCODE_JAL 7'b1101111
`define OPCODE_JALR 7'b1100111
`define OPCODE_BRANCH 7'b1100011
`define OPCODE_MISC_MEM 7'b0001111 // fence, fence.i
`define OPCODE_SYSTEM 7'b1110011 // ecall, ebreak, csr

`endif

//--- source/rv64Pkg.sv
// rv64 core types
`default_nettype none

package rv64Pkg;

	`include "rv64Core_defs.svh"

	typedef logic [`ILEN-1:0] instrWord; // raw instruction
	typedef logic [`XLEN-1:0] xValue; // register contents
	typedef logic [`XLEN-1:0] pcValue; // word index, not byte address
	typedef logic [4:0] regIndex; // x0 .. x31
	typedef logic [`ROM_ADDR_WIDTH-1:0] romIndex;

	// two-beat sequencer
	typedef enum logic {
		beatFetch, // fetch, decode, run jumps
		beatRetire // step pc
	} beatState;

	// one value per decoded instruction
	typedef enum logic [6:0] {
		kindNone, // nothing fetched yet
		// upper immediates
		kindLui,
		kindAuipc,
		// loads
		kindLb, kindLbu, kindLh, kindLhu,
		kindLw, kindLwu, kindLd,
		// stores
		kindSb, kindSh, kindSw, kindSd,
		// register ops
		kindAdd, kindSub, kindSll, kindSlt, kindSltu,
		kindXor, kindSrl, kindSra, kindOr, kindAnd,
		// immediate ops
		kindAddi, kindSlti, kindSltiu, kindXori, kindOri,
		kindAndi, kindSlli, kindSrli, kindSrai,
		// 32-bit immediate ops
		kindAddiw, kindSlliw, kindSrliw, kindSraiw,
		// 32-bit register ops
		kindAddw, kindSubw, kindSllw, kindSrlw, kindSraw,
		// jumps, the only kinds that execute
		kindJal,
		kindJalr,
		// branches
		kindBeq, kindBne, kindBlt, kindBge, kindBltu, kindBgeu,
		// memory ordering
		kindFence,
		kindFencei,
		// environment and csr
		kindEcall, kindEbreak,
		kindCsrrw, kindCsrrs, kindCsrrc,
		kindCsrrwi, kindCsrrsi, kindCsrrci,
		kindIllegal // no table matched
	} instrKind;

endpackage

`default_nettype wire
